//--- src/fe_be_pkg.sv
package fe_be_pkg;

    // widths
    localparam int ADDR_W      = 32;
    localparam int BTB_IDX_W   = 3;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    localparam logic [ADDR_W-1:0] BOOT_PC      = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] TRAP_VEC_RST = 32'h0000_0100;

    // queue message types
    localparam logic MSG_FETCH     = 1'b0;
    localparam logic MSG_EXCEPTION = 1'b1;

    // front end command opcodes
    localparam logic [1:0] CMD_REDIRECT_TAKEN = 2'd0;
    localparam logic [1:0] CMD_REDIRECT_SEQ   = 2'd1;
    localparam logic [1:0] CMD_REDIRECT_TRAP  = 2'd2;
    localparam logic [1:0] CMD_ATTABOY        = 2'd3;

    localparam logic [6:0] OPC_JAL = 7'b1101111;

    localparam logic [1:0] CAUSE_MISALIGNED = 2'd1;

    // register block addresses
    localparam logic [1:0] CSR_TRAP_VEC    = 2'd0;
    localparam logic [1:0] CSR_MISPRED_CNT = 2'd1;
    localparam logic [1:0] CSR_ATTABOY_CNT = 2'd2;

    typedef struct packed {
        logic [ADDR_W-1:0] instr;
        logic [ADDR_W-1:0] pred_npc;
        logic              btb_hit;
    } fe_fetch_s;

    typedef struct packed {
        logic [ADDR_W-1:0] vaddr;
        logic [1:0]        cause;
        logic [30:0]       padding;
    } fe_exception_s;

    // one queue word, read by message type
    typedef union packed {
        fe_fetch_s     fetch;
        fe_exception_s exception;
    } fe_payload_u;

endpackage

//--- src/fe_be_ifs.sv
`timescale 1ns/1ps

// front end to back end message channel
interface fe_queue_if
    import fe_be_pkg::*;
();

    logic              v;
    logic              ready;
    logic              msg_type;
    logic [ADDR_W-1:0] pc;
    fe_payload_u       payload;

    modport producer (output v, msg_type, pc, payload, input ready);
    modport consumer (input v, msg_type, pc, payload, output ready);

endinterface

// back end to front end commands, single-cycle pulse
interface fe_cmd_if
    import fe_be_pkg::*;
();

    logic              v;
    logic [1:0]        opcode;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] branch_pc;

    modport sender (output v, opcode, pc, branch_pc);
    modport receiver (input v, opcode, pc, branch_pc);

endinterface

//--- src/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen
    import fe_be_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    output logic [ADDR_W-1:0] imem_addr_o,
    input  logic [ADDR_W-1:0] imem_data_i,
    fe_queue_if.producer      q,
    fe_cmd_if.receiver        cmd,
    output logic              flush_o
);

    logic [ADDR_W-1:0] pc_r;
    logic              stopped_r;

    // btb state
    logic [BTB_ENTRIES-1:0] btb_v_r;
    logic [ADDR_W-1:0]      btb_tgt_r [BTB_ENTRIES];
    logic [1:0]             btb_cnt_r [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic                 btb_hit;
    logic [ADDR_W-1:0]    pred_npc;
    logic                 misaligned;
    logic                 redirect;
    logic                 push;
    fe_payload_u          payload;

    assign imem_addr_o = pc_r;

    assign rd_idx = pc_r[BTB_IDX_W+1:2];
    assign wr_idx = cmd.branch_pc[BTB_IDX_W+1:2];

    // weakly taken or better counts as a prediction
    assign btb_hit    = btb_v_r[rd_idx] && (btb_cnt_r[rd_idx] >= 2'd2);
    assign pred_npc   = btb_hit ? btb_tgt_r[rd_idx] : pc_r + 32'd4;
    assign misaligned = (pc_r[1:0] != 2'b00);

    assign redirect = cmd.v && (cmd.opcode != CMD_ATTABOY);
    assign flush_o  = redirect;

    always_comb begin
        if (misaligned) begin
            payload.exception.vaddr   = pc_r;
            payload.exception.cause   = CAUSE_MISALIGNED;
            payload.exception.padding = '0;
        end else begin
            payload.fetch.instr    = imem_data_i;
            payload.fetch.pred_npc = pred_npc;
            payload.fetch.btb_hit  = btb_hit;
        end
    end

    // no message in any command cycle
    assign q.v        = !cmd.v && !stopped_r;
    assign q.msg_type = misaligned ? MSG_EXCEPTION : MSG_FETCH;
    assign q.pc       = pc_r;
    assign q.payload  = payload;

    assign push = q.v && q.ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_r      <= BOOT_PC;
            stopped_r <= 1'b0;
        end else if (redirect) begin
            pc_r      <= cmd.pc;
            stopped_r <= 1'b0;
        end else if (push) begin
            if (misaligned) begin
                stopped_r <= 1'b1;
            end else begin
                pc_r <= pred_npc;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            btb_v_r <= '0;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_cnt_r[i] <= 2'd0;
            end
        end else if (cmd.v) begin
            case (cmd.opcode)
                CMD_REDIRECT_TAKEN: begin
                    btb_v_r[wr_idx]   <= 1'b1;
                    btb_cnt_r[wr_idx] <= 2'd2;
                end
                CMD_REDIRECT_SEQ: begin
                    if (btb_cnt_r[wr_idx] != 2'd0) begin
                        btb_cnt_r[wr_idx] <= btb_cnt_r[wr_idx] - 2'd1;
                    end
                end
                CMD_ATTABOY: begin
                    if (btb_cnt_r[wr_idx] != 2'd3) begin
                        btb_cnt_r[wr_idx] <= btb_cnt_r[wr_idx] + 2'd1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd.v && (cmd.opcode == CMD_REDIRECT_TAKEN)) begin
            btb_tgt_r[wr_idx] <= cmd.pc;
        end
    end

    // an attaboy only confirms an entry that already predicted
    assert property (@(posedge clk_i) disable iff (reset_i)
        (cmd.v && (cmd.opcode == CMD_ATTABOY)) |-> btb_v_r[wr_idx]);

endmodule

//--- src/fe_queue.sv
`timescale 1ns/1ps

module fe_queue
    import fe_be_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         flush_i,
    fe_queue_if.consumer enq,
    fe_queue_if.producer deq
);

    logic              type_mem [QUEUE_DEPTH];
    logic [ADDR_W-1:0] pc_mem   [QUEUE_DEPTH];
    fe_payload_u       pl_mem   [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr_r;
    logic [QUEUE_PTR_W-1:0] rd_ptr_r;
    logic [QUEUE_PTR_W:0]   count_r;
    logic                   push;
    logic                   pop;

    assign enq.ready = (count_r != (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
    assign deq.v     = (count_r != '0);

    assign deq.msg_type = type_mem[rd_ptr_r];
    assign deq.pc       = pc_mem[rd_ptr_r];
    assign deq.payload  = pl_mem[rd_ptr_r];

    assign push = enq.v && enq.ready && !flush_i;
    assign pop  = deq.v && deq.ready && !flush_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            count_r <= count_r + (QUEUE_PTR_W+1)'(push) - (QUEUE_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            type_mem[wr_ptr_r] <= enq.msg_type;
            pc_mem[wr_ptr_r]   <= enq.pc;
            pl_mem[wr_ptr_r]   <= enq.payload;
        end
    end

    // a push when full or a pop when empty would take the count out of range
    assert property (@(posedge clk_i) disable iff (reset_i)
        count_r <= (QUEUE_PTR_W+1)'(QUEUE_DEPTH));

    // pointers and count stay in step
    assert property (@(posedge clk_i) disable iff (reset_i)
        (wr_ptr_r - rd_ptr_r) == count_r[QUEUE_PTR_W-1:0]);

endmodule

//--- src/be_checker.sv
`timescale 1ns/1ps

module be_checker
    import fe_be_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    fe_queue_if.consumer      q,
    fe_cmd_if.sender          cmd,
    input  logic [ADDR_W-1:0] trap_vec_i,
    output logic              mispred_o,
    output logic              attaboy_o,
    output logic              commit_v_o,
    output logic [ADDR_W-1:0] commit_pc_o,
    output logic [ADDR_W-1:0] commit_instr_o
);

    logic              cmd_v_r;
    logic [1:0]        cmd_op_r;
    logic [ADDR_W-1:0] cmd_pc_r;
    logic [ADDR_W-1:0] cmd_bpc_r;
    logic              redir_pend_r;

    logic              pop;
    logic [ADDR_W-1:0] instr;
    logic              is_jal;
    logic [ADDR_W-1:0] j_imm;
    logic [ADDR_W-1:0] actual_npc;
    logic              mismatch;

    assign cmd.v         = cmd_v_r;
    assign cmd.opcode    = cmd_op_r;
    assign cmd.pc        = cmd_pc_r;
    assign cmd.branch_pc = cmd_bpc_r;

    // stall while a redirect is on its way to the front end
    assign q.ready = !redir_pend_r;
    assign pop     = q.v && q.ready;

    assign instr  = q.payload.fetch.instr;
    assign is_jal = (instr[6:0] == OPC_JAL);
    assign j_imm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign actual_npc = is_jal ? q.pc + j_imm : q.pc + 32'd4;
    assign mismatch   = (actual_npc != q.payload.fetch.pred_npc);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmd_v_r      <= 1'b0;
            redir_pend_r <= 1'b0;
            commit_v_o   <= 1'b0;
            mispred_o    <= 1'b0;
            attaboy_o    <= 1'b0;
        end else begin
            cmd_v_r      <= 1'b0;
            redir_pend_r <= 1'b0;
            commit_v_o   <= 1'b0;
            mispred_o    <= 1'b0;
            attaboy_o    <= 1'b0;
            if (pop) begin
                if (q.msg_type == MSG_FETCH) begin
                    commit_v_o <= 1'b1;
                    if (mismatch) begin
                        cmd_v_r      <= 1'b1;
                        redir_pend_r <= 1'b1;
                        mispred_o    <= 1'b1;
                    end else if (is_jal && q.payload.fetch.btb_hit) begin
                        cmd_v_r   <= 1'b1;
                        attaboy_o <= 1'b1;
                    end
                end else begin
                    cmd_v_r      <= 1'b1;
                    redir_pend_r <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            commit_pc_o    <= q.pc;
            commit_instr_o <= instr;
            if (q.msg_type == MSG_EXCEPTION) begin
                cmd_op_r  <= CMD_REDIRECT_TRAP;
                cmd_pc_r  <= trap_vec_i;
                cmd_bpc_r <= q.payload.exception.vaddr;
            end else begin
                if (!mismatch) begin
                    cmd_op_r <= CMD_ATTABOY;
                end else if (is_jal) begin
                    cmd_op_r <= CMD_REDIRECT_TAKEN;
                end else begin
                    cmd_op_r <= CMD_REDIRECT_SEQ;
                end
                cmd_pc_r  <= actual_npc;
                cmd_bpc_r <= q.pc;
            end
        end
    end

    // nothing is popped in the cycle the front end is being redirected
    assert property (@(posedge clk_i) disable iff (reset_i)
        (cmd.v && (cmd.opcode != CMD_ATTABOY)) |-> !q.ready);

endmodule

//--- src/be_csr_regs.sv
`timescale 1ns/1ps

module be_csr_regs
    import fe_be_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              csr_w_v_i,
    input  logic [1:0]        csr_addr_i,
    input  logic [ADDR_W-1:0] csr_wdata_i,
    output logic [ADDR_W-1:0] csr_rdata_o,
    input  logic              mispred_i,
    input  logic              attaboy_i,
    output logic [ADDR_W-1:0] trap_vec_o
);

    logic [ADDR_W-1:0] trap_vec_r;
    logic [ADDR_W-1:0] mispred_cnt_r;
    logic [ADDR_W-1:0] attaboy_cnt_r;

    assign trap_vec_o = trap_vec_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trap_vec_r    <= TRAP_VEC_RST;
            mispred_cnt_r <= '0;
            attaboy_cnt_r <= '0;
        end else begin
            if (csr_w_v_i && (csr_addr_i == CSR_TRAP_VEC)) begin
                trap_vec_r <= csr_wdata_i;
            end
            // a write clears, and wins over an increment
            if (csr_w_v_i && (csr_addr_i == CSR_MISPRED_CNT)) begin
                mispred_cnt_r <= '0;
            end else if (mispred_i) begin
                mispred_cnt_r <= mispred_cnt_r + 32'd1;
            end
            if (csr_w_v_i && (csr_addr_i == CSR_ATTABOY_CNT)) begin
                attaboy_cnt_r <= '0;
            end else if (attaboy_i) begin
                attaboy_cnt_r <= attaboy_cnt_r + 32'd1;
            end
        end
    end

    always_comb begin
        case (csr_addr_i)
            CSR_TRAP_VEC:    csr_rdata_o = trap_vec_r;
            CSR_MISPRED_CNT: csr_rdata_o = mispred_cnt_r;
            CSR_ATTABOY_CNT: csr_rdata_o = attaboy_cnt_r;
            default:         csr_rdata_o = '0;
        endcase
    end

endmodule

//--- src/fe_be_top.sv
`timescale 1ns/1ps

module fe_be_top
    import fe_be_pkg::*;
(
    input  logic              clk_i,
    input  logic              reset_i,
    output logic [ADDR_W-1:0] imem_addr_o,
    input  logic [ADDR_W-1:0] imem_data_i,
    input  logic              csr_w_v_i,
    input  logic [1:0]        csr_addr_i,
    input  logic [ADDR_W-1:0] csr_wdata_i,
    output logic [ADDR_W-1:0] csr_rdata_o,
    output logic              commit_v_o,
    output logic [ADDR_W-1:0] commit_pc_o,
    output logic [ADDR_W-1:0] commit_instr_o
);

    logic              flush;
    logic              mispred;
    logic              attaboy;
    logic [ADDR_W-1:0] trap_vec;

    fe_queue_if fe_q_if ();
    fe_queue_if be_q_if ();
    fe_cmd_if   cmd_if ();

    fe_pc_gen pc_gen_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .q           (fe_q_if.producer),
        .cmd         (cmd_if.receiver),
        .flush_o     (flush)
    );

    fe_queue queue_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush),
        .enq     (fe_q_if.consumer),
        .deq     (be_q_if.producer)
    );

    be_checker checker_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .q              (be_q_if.consumer),
        .cmd            (cmd_if.sender),
        .trap_vec_i     (trap_vec),
        .mispred_o      (mispred),
        .attaboy_o      (attaboy),
        .commit_v_o     (commit_v_o),
        .commit_pc_o    (commit_pc_o),
        .commit_instr_o (commit_instr_o)
    );

    be_csr_regs csr_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .csr_w_v_i   (csr_w_v_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .mispred_i   (mispred),
        .attaboy_i   (attaboy),
        .trap_vec_o  (trap_vec)
    );

endmodule

//--- verification/fe_be_tb.sv
`timescale 1ns/1ps

module fe_be_tb
    import fe_be_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int MODEL_MARGIN = 16;
    localparam int N_STRAIGHT   = 12;
    localparam int N_FORWARD    = 7;
    localparam int N_LOOP       = 21;
    localparam int N_ALIAS      = 20;
    localparam int N_TRAP       = 10;
    localparam int CYCLE_LIMIT  = 40 * (N_STRAIGHT + N_FORWARD + N_LOOP + N_ALIAS + N_TRAP);

    logic              clk_i;
    logic              reset_i;
    logic [ADDR_W-1:0] imem_addr_o;
    logic [ADDR_W-1:0] imem_data_i;
    logic              csr_w_v_i;
    logic [1:0]        csr_addr_i;
    logic [ADDR_W-1:0] csr_wdata_i;
    logic [ADDR_W-1:0] csr_rdata_o;
    logic              commit_v_o;
    logic [ADDR_W-1:0] commit_pc_o;
    logic [ADDR_W-1:0] commit_instr_o;

    // instruction memory, plus what each word means to the model
    logic [ADDR_W-1:0] imem    [MEM_WORDS];
    logic              jal_at  [MEM_WORDS];
    logic [ADDR_W-1:0] jal_off [MEM_WORDS];
    logic [ADDR_W-1:0] model_trap_vec;

    // expected commits with their counter increments
    logic [ADDR_W-1:0] exp_pc    [$];
    logic [ADDR_W-1:0] exp_instr [$];
    logic              exp_mis   [$];
    logic              exp_att   [$];

    int                cycle_cnt;
    int                commit_idx;
    logic [ADDR_W-1:0] mis_sum;
    logic [ADDR_W-1:0] att_sum;
    logic [ADDR_W-1:0] mis_before;
    logic [ADDR_W-1:0] att_before;

    fe_be_top dut_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .imem_addr_o    (imem_addr_o),
        .imem_data_i    (imem_data_i),
        .csr_w_v_i      (csr_w_v_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_rdata_o    (csr_rdata_o),
        .commit_v_o     (commit_v_o),
        .commit_pc_o    (commit_pc_o),
        .commit_instr_o (commit_instr_o)
    );

    assign imem_data_i = imem[imem_addr_o[9:2]];

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // filler is never a jump
    function automatic logic [ADDR_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'b0010011};
    endfunction

    function automatic logic [ADDR_W-1:0] jal_word(input logic [ADDR_W-1:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_commit(input logic [ADDR_W-1:0] got_pc, input logic [ADDR_W-1:0] exp_p,
                                input logic [ADDR_W-1:0] got_ins, input logic [ADDR_W-1:0] exp_i);
        if (got_pc !== exp_p) begin
            fail_run($sformatf("Mismatch commit_pc_o: got %h, expected %h", got_pc, exp_p));
        end else if (got_ins !== exp_i) begin
            fail_run($sformatf("Mismatch commit_instr_o: got %h, expected %h", got_ins, exp_i));
        end
    endtask

    task automatic check_csr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp_v);
        if (got !== exp_v) begin
            fail_run($sformatf("Mismatch csr_rdata_o (%s): got %h, expected %h", name, got, exp_v));
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]    = fill_word(ADDR_W'(i) << 2);
            jal_at[i]  = 1'b0;
            jal_off[i] = '0;
        end
        model_trap_vec = TRAP_VEC_RST;
    endtask

    task automatic place_jal(input logic [ADDR_W-1:0] addr, input int off);
        logic [ADDR_W-1:0] o;
        o = off;
        imem[addr[9:2]]    = jal_word(o);
        jal_at[addr[9:2]]  = 1'b1;
        jal_off[addr[9:2]] = o;
    endtask

    // architectural order, with an in-order copy of the predictor
    task automatic build_expected(input int n);
        logic              v   [8];
        logic [ADDR_W-1:0] tgt [8];
        logic [1:0]        cnt [8];
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] pred;
        logic [ADDR_W-1:0] actual;
        logic              hit;
        logic              jal;
        int                w;
        int                idx;
        exp_pc.delete();
        exp_instr.delete();
        exp_mis.delete();
        exp_att.delete();
        for (int i = 0; i < 8; i++) begin
            v[i]   = 1'b0;
            tgt[i] = '0;
            cnt[i] = 2'd0;
        end
        pc = BOOT_PC;
        for (int k = 0; k < n; k++) begin
            w      = int'(pc[9:2]);
            idx    = int'(pc[4:2]);
            jal    = jal_at[w];
            hit    = v[idx] && (cnt[idx] >= 2'd2);
            pred   = hit ? tgt[idx] : pc + 32'd4;
            actual = jal ? pc + jal_off[w] : pc + 32'd4;
            exp_pc.push_back(pc);
            exp_instr.push_back(imem[w]);
            exp_mis.push_back(actual != pred);
            exp_att.push_back((actual == pred) && jal && hit);
            if (actual != pred) begin
                if (jal) begin
                    v[idx]   = 1'b1;
                    tgt[idx] = actual;
                    cnt[idx] = 2'd2;
                end else if (cnt[idx] != 2'd0) begin
                    cnt[idx] = cnt[idx] - 2'd1;
                end
            end else if (jal && hit && (cnt[idx] != 2'd3)) begin
                cnt[idx] = cnt[idx] + 2'd1;
            end
            // misaligned target traps, nothing committed there
            pc = (actual[1:0] != 2'b00) ? model_trap_vec : actual;
        end
    endtask

    // a counter read at this negedge holds the pulses of all earlier commits
    task automatic watch_cycle();
        @(negedge clk_i);
        cycle_cnt++;
        mis_before = mis_sum;
        att_before = att_sum;
        if (cycle_cnt > CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles, commits stopped arriving", cycle_cnt));
        end else if (commit_v_o) begin
            if (commit_idx >= exp_pc.size()) begin
                fail_run("more commits arrived than the golden model produced");
            end else begin
                check_commit(commit_pc_o, exp_pc[commit_idx],
                             commit_instr_o, exp_instr[commit_idx]);
                mis_sum = mis_sum + ADDR_W'(exp_mis[commit_idx]);
                att_sum = att_sum + ADDR_W'(exp_att[commit_idx]);
                commit_idx++;
            end
        end
    endtask

    task automatic drive_cycle(input logic w_v, input logic [1:0] addr,
                               input logic [ADDR_W-1:0] wdata);
        @(posedge clk_i);
        csr_w_v_i   <= w_v;
        csr_addr_i  <= addr;
        csr_wdata_i <= wdata;
        watch_cycle();
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i   <= 1'b1;
        csr_w_v_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        commit_idx = 0;
        mis_sum    = '0;
        att_sum    = '0;
        watch_cycle();
    endtask

    task automatic wait_commits(input int n);
        while (commit_idx < n) begin
            drive_cycle(1'b0, CSR_TRAP_VEC, '0);
        end
    endtask

    task automatic read_csr(input logic [1:0] addr, output logic [ADDR_W-1:0] data);
        drive_cycle(1'b0, addr, '0);
        data = csr_rdata_o;
    endtask

    task automatic write_csr(input logic [1:0] addr, input logic [ADDR_W-1:0] data);
        drive_cycle(1'b1, addr, data);
        // the clear also swallows a pulse of the write cycle
        if (addr == CSR_MISPRED_CNT) begin
            mis_sum = '0;
        end
        if (addr == CSR_ATTABOY_CNT) begin
            att_sum = '0;
        end
    endtask

    task automatic check_counters();
        logic [ADDR_W-1:0] val;
        read_csr(CSR_MISPRED_CNT, val);
        check_csr("mispred_cnt", val, mis_before);
        read_csr(CSR_ATTABOY_CNT, val);
        check_csr("attaboy_cnt", val, att_before);
    endtask

    task automatic run_and_check(input int n);
        build_expected(n + MODEL_MARGIN);
        apply_reset();
        wait_commits(n);
        check_counters();
    endtask

    task automatic test_straight_line();
        clear_program();
        run_and_check(N_STRAIGHT);
    endtask

    task automatic test_forward_jal();
        clear_program();
        place_jal(32'h0000_0008, 16);
        run_and_check(N_FORWARD);
    endtask

    task automatic test_backward_loop();
        clear_program();
        place_jal(32'h0000_0010, -12);
        run_and_check(N_LOOP);
    endtask

    // both jumps sit on btb index 2
    task automatic test_aliasing_jals();
        clear_program();
        place_jal(32'h0000_0008, 32);
        place_jal(32'h0000_0028, -36);
        run_and_check(N_ALIAS);
    endtask

    task automatic test_misaligned_trap();
        logic [ADDR_W-1:0] val;
        clear_program();
        place_jal(32'h0000_0010, 34);
        model_trap_vec = 32'h0000_0200;
        build_expected(N_TRAP + MODEL_MARGIN);
        apply_reset();
        write_csr(CSR_TRAP_VEC, model_trap_vec);
        read_csr(CSR_TRAP_VEC, val);
        check_csr("trap_vec", val, model_trap_vec);
        wait_commits(N_TRAP);
        check_counters();
        write_csr(CSR_MISPRED_CNT, '0);
        read_csr(CSR_MISPRED_CNT, val);
        check_csr("mispred_cnt after clear", val, mis_before);
    endtask

    initial begin
        reset_i     = 1'b1;
        csr_w_v_i   = 1'b0;
        csr_addr_i  = CSR_TRAP_VEC;
        csr_wdata_i = '0;
        cycle_cnt   = 0;
        commit_idx  = 0;
        mis_sum     = '0;
        att_sum     = '0;
        clear_program();
        test_straight_line();
        test_forward_jal();
        test_backward_loop();
        test_aliasing_jals();
        test_misaligned_trap();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- fe_be_top.f
src/fe_be_pkg.sv
src/fe_be_ifs.sv
src/fe_pc_gen.sv
src/fe_queue.sv
src/be_checker.sv
src/be_csr_regs.sv
src/fe_be_top.sv
verification/fe_be_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fe_be_tb
FILELIST  = fe_be_top.f
OBJ_DIR   = obj_dir

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
